/* Makefile */
VERILATOR  ?= verilator
FILELIST   := list.f
TB_TOP     := tb_axi_bridge
RTL_TOP    := axi_bridge_top
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -o $(TB_TOP)
	./$(OBJ_DIR)/$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "no verdict in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/axi_bridge_config.svh */
`ifndef AXI_BRIDGE_CONFIG_SVH
`define AXI_BRIDGE_CONFIG_SVH

// bus and line geometry
`define ADDR_WD 32
`define WORD_WD 32
`define LINE_BEATS 4
`define LINE_WD 128

// axi ids
`define AXI_ID_WD 4
`define INST_RD_ID 0
`define DATA_RD_ID 1
`define WR_ID 1

// fixed AXI attributes, not driven as ports
// arsize/awsize = 3'b010, 4 bytes per beat
// arburst/awburst = 2'b01, INCR
// lock, cache and prot all zero
// every burst is either 1 beat (len 0) or LINE_BEATS beats (len 3)

`endif

/* design/axi_bridge_pkg.sv */
`include "axi_bridge_config.svh"

package axi_bridge_pkg;

	typedef logic [`ADDR_WD-1:0] addr_t;
	typedef logic [`WORD_WD-1:0] word_t;
	typedef logic [`LINE_WD-1:0] line_t;
	typedef logic [`WORD_WD/8-1:0] strb_t;
	typedef logic [`AXI_ID_WD-1:0] axi_id_t;
	typedef logic [$clog2(`LINE_BEATS)-1:0] beat_cnt_t;

	// uncached word or full line refill
	typedef enum logic {
		XFER_WORD,
		XFER_LINE
	} xfer_kind_e;

	typedef struct packed {
		addr_t      addr;
		xfer_kind_e kind;
	} rd_req_t;

	typedef struct packed {
		logic  valid;
		logic  last;
		word_t data;
	} rd_ret_t;

	typedef struct packed {
		addr_t      addr;
		xfer_kind_e kind;
		strb_t      strb;
		line_t      line;
	} wr_req_t;

	typedef struct packed {
		axi_id_t    id;
		addr_t      addr;
		logic [7:0] len;
	} ar_chan_t;

	typedef ar_chan_t aw_chan_t;

	typedef struct packed {
		axi_id_t    id;
		word_t      data;
		logic [1:0] resp;
		logic       last;
	} r_chan_t;

	typedef struct packed {
		word_t data;
		strb_t strb;
		logic  last;
	} w_chan_t;

	typedef struct packed {
		axi_id_t    id;
		logic [1:0] resp;
	} b_chan_t;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_state_e;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	// clear the byte offset within a line
	function automatic addr_t line_base(addr_t a);
		return a & ~addr_t'(`LINE_WD/8 - 1);
	endfunction

endpackage

/* design/axi_bridge_top.sv */
`timescale 1ns/1ps
`include "axi_bridge_config.svh"

module axi_bridge_top import axi_bridge_pkg::*; (
	input  logic     clk,
	input  logic     reset,

	input  logic     inst_req_i,
	input  rd_req_t  inst_rd_i,
	output logic     inst_rdy_o,
	output rd_ret_t  inst_ret_o,

	input  logic     data_req_i,
	input  rd_req_t  data_rd_i,
	output logic     data_rdy_o,
	output rd_ret_t  data_ret_o,

	input  logic     wr_req_i,
	input  wr_req_t  wr_i,
	output logic     wr_rdy_o,

	output ar_chan_t ar_o,
	output logic     arvalid_o,
	input  logic     arready_i,
	input  r_chan_t  r_i,
	input  logic     rvalid_i,
	output logic     rready_o,

	output aw_chan_t aw_o,
	output logic     awvalid_o,
	input  logic     awready_i,
	output w_chan_t  w_o,
	output logic     wvalid_o,
	input  logic     wready_i,
	input  b_chan_t  b_i,
	input  logic     bvalid_i,
	output logic     bready_o
);

	// write-in-flight info for the read guard
	logic  wr_busy;
	addr_t wr_line;

	refill_read_engine u_rd (
		.clk        (clk),
		.reset      (reset),
		.inst_req_i (inst_req_i),
		.inst_rd_i  (inst_rd_i),
		.inst_rdy_o (inst_rdy_o),
		.inst_ret_o (inst_ret_o),
		.data_req_i (data_req_i),
		.data_rd_i  (data_rd_i),
		.data_rdy_o (data_rdy_o),
		.data_ret_o (data_ret_o),
		.wr_busy_i  (wr_busy),
		.wr_line_i  (wr_line),
		.ar_o       (ar_o),
		.arvalid_o  (arvalid_o),
		.arready_i  (arready_i),
		.r_i        (r_i),
		.rvalid_i   (rvalid_i),
		.rready_o   (rready_o)
	);

	writeback_engine u_wr (
		.clk       (clk),
		.reset     (reset),
		.wr_req_i  (wr_req_i),
		.wr_i      (wr_i),
		.wr_rdy_o  (wr_rdy_o),
		.wr_busy_o (wr_busy),
		.wr_line_o (wr_line),
		.aw_o      (aw_o),
		.awvalid_o (awvalid_o),
		.awready_i (awready_i),
		.w_o       (w_o),
		.wvalid_o  (wvalid_o),
		.wready_i  (wready_i),
		.b_i       (b_i),
		.bvalid_i  (bvalid_i),
		.bready_o  (bready_o)
	);

endmodule

/* design/refill_read_engine.sv */
`timescale 1ns/1ps
`include "axi_bridge_config.svh"

module refill_read_engine import axi_bridge_pkg::*; (
	input  logic     clk,
	input  logic     reset,

	input  logic     inst_req_i,
	input  rd_req_t  inst_rd_i,
	output logic     inst_rdy_o,
	output rd_ret_t  inst_ret_o,

	input  logic     data_req_i,
	input  rd_req_t  data_rd_i,
	output logic     data_rdy_o,
	output rd_ret_t  data_ret_o,

	input  logic     wr_busy_i,
	input  addr_t    wr_line_i,

	output ar_chan_t ar_o,
	output logic     arvalid_o,
	input  logic     arready_i,
	input  r_chan_t  r_i,
	input  logic     rvalid_i,
	output logic     rready_o
);

	rd_state_e state;
	rd_state_e state_nxt;
	ar_chan_t  ar_q;
	logic      data_hit_wr;
	logic      inst_hit_wr;
	logic      data_take;
	logic      inst_take;
	rd_req_t   pick;
	axi_id_t   pick_id;
	logic      r_fire;

	// hold off reads that hit the line of a write still in flight
	assign data_hit_wr = wr_busy_i && (line_base(data_rd_i.addr) == wr_line_i);
	assign inst_hit_wr = wr_busy_i && (line_base(inst_rd_i.addr) == wr_line_i);

	assign data_rdy_o = (state == RD_IDLE) && !data_hit_wr;
	assign data_take  = data_req_i && data_rdy_o;

	// data side wins a same-cycle tie
	assign inst_rdy_o = (state == RD_IDLE) && !inst_hit_wr && !data_take;
	assign inst_take  = inst_req_i && inst_rdy_o;

	assign pick    = data_take ? data_rd_i : inst_rd_i;
	assign pick_id = data_take ? axi_id_t'(`DATA_RD_ID) : axi_id_t'(`INST_RD_ID);

	always_comb begin
		state_nxt = state;
		case (state)
			RD_IDLE: begin
				if (data_take || inst_take) begin
					state_nxt = RD_ADDR;
				end
			end
			RD_ADDR: begin
				if (arready_i) begin
					state_nxt = RD_DATA;
				end
			end
			RD_DATA: begin
				if (rvalid_i && r_i.last) begin
					state_nxt = RD_IDLE;
				end
			end
			default: begin
				state_nxt = RD_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RD_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// AR payload, held until the burst is done
	always_ff @(posedge clk) begin
		if (data_take || inst_take) begin
			ar_q.id <= pick_id;
			if (pick.kind == XFER_LINE) begin
				ar_q.addr <= line_base(pick.addr);
				ar_q.len  <= 8'(`LINE_BEATS - 1);
			end else begin
				ar_q.addr <= pick.addr;
				ar_q.len  <= 8'd0;
			end
		end
	end

	assign ar_o      = ar_q;
	assign arvalid_o = (state == RD_ADDR);

	// clients cannot stall returns
	assign rready_o = (state == RD_DATA);
	assign r_fire   = rready_o && rvalid_i;

	// steer each beat by its id
	always_comb begin
		inst_ret_o.valid = r_fire && (r_i.id == axi_id_t'(`INST_RD_ID));
		inst_ret_o.last  = r_i.last;
		inst_ret_o.data  = r_i.data;
		data_ret_o.valid = r_fire && (r_i.id == axi_id_t'(`DATA_RD_ID));
		data_ret_o.last  = r_i.last;
		data_ret_o.data  = r_i.data;
	end

	property p_ar_hold;
		@(posedge clk) disable iff (reset)
		arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o);
	endproperty
	a_ar_hold: assert property (p_ar_hold)
		else $error("arvalid dropped or ar_o changed before arready");

	// slave must answer with the id we issued
	property p_r_id;
		@(posedge clk) disable iff (reset)
		(state == RD_DATA) && rvalid_i |-> r_i.id == ar_q.id;
	endproperty
	a_r_id: assert property (p_r_id)
		else $error("R beat id %0h does not match issued id %0h", r_i.id, ar_q.id);

endmodule

/* design/writeback_engine.sv */
`timescale 1ns/1ps
`include "axi_bridge_config.svh"

module writeback_engine import axi_bridge_pkg::*; (
	input  logic     clk,
	input  logic     reset,

	input  logic     wr_req_i,
	input  wr_req_t  wr_i,
	output logic     wr_rdy_o,

	output logic     wr_busy_o,
	output addr_t    wr_line_o,

	output aw_chan_t aw_o,
	output logic     awvalid_o,
	input  logic     awready_i,
	output w_chan_t  w_o,
	output logic     wvalid_o,
	input  logic     wready_i,
	input  b_chan_t  b_i,
	input  logic     bvalid_i,
	output logic     bready_o
);

	wr_state_e  state;
	wr_state_e  state_nxt;
	aw_chan_t   aw_q;
	line_t      line_q;
	strb_t      strb_q;
	xfer_kind_e kind_q;
	beat_cnt_t  beat_q;
	logic       accept;
	logic       w_fire;
	logic       last_beat;

	assign wr_rdy_o  = (state == WR_IDLE);
	assign accept    = wr_req_i && wr_rdy_o;
	assign w_fire    = wvalid_o && wready_i;
	assign last_beat = (kind_q == XFER_WORD) || (beat_q == beat_cnt_t'(`LINE_BEATS - 1));

	// busy already in the accepting cycle, so a read of this line waits
	assign wr_busy_o = accept || (state != WR_IDLE);
	assign wr_line_o = (state == WR_IDLE) ? line_base(wr_i.addr) : line_base(aw_q.addr);

	always_comb begin
		state_nxt = state;
		case (state)
			WR_IDLE: begin
				if (accept) begin
					state_nxt = WR_ADDR;
				end
			end
			WR_ADDR: begin
				if (awready_i) begin
					state_nxt = WR_DATA;
				end
			end
			WR_DATA: begin
				if (wready_i && last_beat) begin
					state_nxt = WR_RESP;
				end
			end
			WR_RESP: begin
				if (bvalid_i) begin
					state_nxt = WR_IDLE;
				end
			end
			default: begin
				state_nxt = WR_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= WR_IDLE;
			beat_q <= '0;
		end else begin
			state <= state_nxt;
			if (accept) begin
				beat_q <= '0;
			end else if (w_fire) begin
				beat_q <= beat_q + 1'b1;
			end
		end
	end

	// capture the write, then shift one word out per accepted beat
	always_ff @(posedge clk) begin
		if (accept) begin
			aw_q.id <= axi_id_t'(`WR_ID);
			kind_q  <= wr_i.kind;
			line_q  <= wr_i.line;
			if (wr_i.kind == XFER_LINE) begin
				aw_q.addr <= line_base(wr_i.addr);
				aw_q.len  <= 8'(`LINE_BEATS - 1);
				strb_q    <= '1;
			end else begin
				aw_q.addr <= wr_i.addr;
				aw_q.len  <= 8'd0;
				strb_q    <= wr_i.strb;
			end
		end else if (w_fire) begin
			line_q <= line_q >> `WORD_WD;
		end
	end

	assign aw_o      = aw_q;
	assign awvalid_o = (state == WR_ADDR);

	assign wvalid_o = (state == WR_DATA);
	assign w_o.data = line_q[`WORD_WD-1:0];
	assign w_o.strb = strb_q;
	assign w_o.last = last_beat;

	assign bready_o = (state == WR_RESP);

	// W may only start right after the AW handshake
	property p_w_after_aw;
		@(posedge clk) disable iff (reset)
		$rose(wvalid_o) |-> $past(awvalid_o && awready_i);
	endproperty
	a_w_after_aw: assert property (p_w_after_aw)
		else $error("wvalid raised without a preceding AW handshake");

	// wlast lands on the beat the AW length promised, then W goes quiet
	property p_wlast;
		@(posedge clk) disable iff (reset)
		w_fire && w_o.last |-> (beat_q == beat_cnt_t'(aw_o.len)) ##1 !wvalid_o;
	endproperty
	a_wlast: assert property (p_wlast)
		else $error("wlast at beat %0d, awlen %0d", beat_q, aw_o.len);

	property p_b_id;
		@(posedge clk) disable iff (reset)
		bvalid_i && bready_o |-> b_i.id == axi_id_t'(`WR_ID);
	endproperty
	a_b_id: assert property (p_b_id)
		else $error("B response id %0h is not the write id", b_i.id);

endmodule

/* list.f */
+incdir+design
design/axi_bridge_pkg.sv
design/refill_read_engine.sv
design/writeback_engine.sv
design/axi_bridge_top.sv
tb/bridge_checker.sv
tb/tb_axi_bridge.sv

/* tb/bridge_checker.sv */
`timescale 1ns/1ps
`include "axi_bridge_config.svh"

module bridge_checker import axi_bridge_pkg::*; #(
	parameter word_t MEM_PAT = '0
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    inst_req_i,
	input  rd_req_t inst_rd_i,
	input  logic    inst_rdy_i,
	input  rd_ret_t inst_ret_i,
	input  logic    data_req_i,
	input  rd_req_t data_rd_i,
	input  logic    data_rdy_i,
	input  rd_ret_t data_ret_i,
	input  logic    wr_req_i,
	input  wr_req_t wr_i,
	input  logic    wr_rdy_i,
	input  logic    arvalid_i,
	input  logic    rready_i,
	input  aw_chan_t aw_i,
	input  logic    awvalid_i,
	input  logic    awready_i,
	input  logic    wvalid_i,
	input  logic    bvalid_i,
	input  logic    bready_i,
	input  logic    end_check_i,
	output int      errors_o
);

	word_t    ref_mem [0:255];
	word_t    inst_exp [$];
	word_t    data_exp [$];
	aw_chan_t aw_exp;
	logic     wr_out = 1'b0;
	int       errors = 0;

	assign errors_o = errors;

	initial begin
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = word_t'(i * 4) ^ MEM_PAT;
		end
	end

	// line writes fill four words, word writes merge lane 0 by strobe
	task automatic mirror_write(input wr_req_t w);
		logic [7:0] idx;
		idx = w.addr[9:2];
		if (w.kind == XFER_LINE) begin
			idx[1:0] = 2'b00;
			for (int k = 0; k < `LINE_BEATS; k++) begin
				ref_mem[idx + 8'(k)] = w.line[k*32 +: 32];
			end
		end else begin
			for (int b = 0; b < 4; b++) begin
				if (w.strb[b]) begin
					ref_mem[idx][b*8 +: 8] = w.line[b*8 +: 8];
				end
			end
		end
	endtask

	// line bursts start at the line base
	function automatic aw_chan_t expected_aw(input wr_req_t w);
		aw_chan_t a;
		a.id   = axi_id_t'(`WR_ID);
		a.addr = w.addr;
		a.len  = 8'd0;
		if (w.kind == XFER_LINE) begin
			a.addr[3:0] = 4'h0;
			a.len       = 8'(`LINE_BEATS - 1);
		end
		return a;
	endfunction

	task automatic expect_read(input rd_req_t rq, input logic is_data);
		logic [7:0] idx;
		int         n;
		idx = rq.addr[9:2];
		n = 1;
		if (rq.kind == XFER_LINE) begin
			idx[1:0] = 2'b00;
			n = `LINE_BEATS;
		end
		for (int k = 0; k < n; k++) begin
			if (is_data) begin
				data_exp.push_back(ref_mem[idx + 8'(k)]);
			end else begin
				inst_exp.push_back(ref_mem[idx + 8'(k)]);
			end
		end
	endtask

	task automatic check_beat(input string port, input rd_ret_t ret, input word_t exp,
		input logic exp_last);
		if (ret.data !== exp) begin
			$display("mismatch %s.data: got %08h expected %08h", port, ret.data, exp);
			errors++;
		end
		if (ret.last !== exp_last) begin
			$display("mismatch %s.last: got %0h expected %0h", port, ret.last, exp_last);
			errors++;
		end
	endtask

	always @(posedge clk) begin
		logic  idle;
		word_t exp;
		if (reset) begin
			inst_exp.delete();
			data_exp.delete();
			wr_out = 1'b0;
		end else begin
			idle = inst_exp.size() == 0 && data_exp.size() == 0 && !wr_out
				&& !inst_req_i && !data_req_i && !wr_req_i;
			if (idle && (arvalid_i || rready_i || awvalid_i || wvalid_i || bready_i
				|| inst_ret_i.valid || data_ret_i.valid
				|| !inst_rdy_i || !data_rdy_i || !wr_rdy_i)) begin
				$display("bridge is not quiet while no transfer is pending");
				errors++;
			end
			// data side wins a same-cycle tie
			if (inst_req_i && inst_rdy_i && data_req_i && !data_rdy_i && !wr_out && !wr_req_i) begin
				$display("instruction read accepted ahead of a pending data read");
				errors++;
			end
			if (inst_ret_i.valid) begin
				if (inst_exp.size() == 0) begin
					$display("return beat on inst_ret_o with no instruction read outstanding");
					errors++;
				end else begin
					exp = inst_exp.pop_front();
					check_beat("inst_ret_o", inst_ret_i, exp, inst_exp.size() == 0);
				end
			end
			if (data_ret_i.valid) begin
				if (data_exp.size() == 0) begin
					$display("return beat on data_ret_o with no data read outstanding");
					errors++;
				end else begin
					exp = data_exp.pop_front();
					check_beat("data_ret_o", data_ret_i, exp, data_exp.size() == 0);
				end
			end
			if (awvalid_i && awready_i && aw_i !== aw_exp) begin
				$display("mismatch aw_o: got %011h expected %011h", aw_i, aw_exp);
				errors++;
			end
			if (bvalid_i && bready_i) begin
				wr_out = 1'b0;
			end
			if (wr_req_i && wr_rdy_i) begin
				mirror_write(wr_i);
				aw_exp = expected_aw(wr_i);
				wr_out = 1'b1;
			end
			if (data_req_i && data_rdy_i) begin
				expect_read(data_rd_i, 1'b1);
			end
			if (inst_req_i && inst_rdy_i) begin
				expect_read(inst_rd_i, 1'b0);
			end
			if (end_check_i && (inst_exp.size() != 0 || data_exp.size() != 0 || wr_out)) begin
				$display("read returns or a write response still missing at end of run");
				errors++;
			end
		end
	end

endmodule

/* tb/tb_axi_bridge.sv */
`timescale 1ns/1ps
`include "axi_bridge_config.svh"

module tb_axi_bridge import axi_bridge_pkg::*; ();

	localparam int    NUM_ROWS = 13;
	localparam int    TIMEOUT_CYCLES = NUM_ROWS * 40;
	localparam word_t MEM_PAT = 32'h5a5a_c3c3;

	typedef enum logic [1:0] {
		CL_INST,
		CL_DATA,
		CL_BOTH,
		CL_WR
	} client_e;

	typedef struct packed {
		client_e    client;
		xfer_kind_e kind;
		addr_t      addr;
		strb_t      strb;
		line_t      line;
	} stim_t;

	logic     clk;
	logic     reset;
	logic     inst_req_i, data_req_i, wr_req_i;
	rd_req_t  inst_rd_i, data_rd_i;
	wr_req_t  wr_i;
	logic     inst_rdy_o, data_rdy_o, wr_rdy_o;
	rd_ret_t  inst_ret_o, data_ret_o;
	ar_chan_t ar_o;
	aw_chan_t aw_o;
	w_chan_t  w_o;
	logic     arvalid_o, rready_o, awvalid_o, wvalid_o, bready_o;
	logic     arready_i = 1'b0;
	logic     rvalid_i = 1'b0;
	logic     awready_i = 1'b0;
	logic     wready_i = 1'b0;
	logic     bvalid_i = 1'b0;
	r_chan_t  r_i = '0;
	b_chan_t  b_i = '0;
	logic     end_check = 1'b0;
	int       errors;
	int       cycles = 0;
	stim_t    rows [NUM_ROWS];

	// slave model state
	word_t      mem [0:255];
	logic [1:0] rd_wait, wr_wait, wr_phase;
	logic       rd_busy;
	axi_id_t    rd_id, wr_id;
	addr_t      rd_addr, wr_addr;
	logic [7:0] rd_left;

	axi_bridge_top u_dut (.*);

	bridge_checker #(.MEM_PAT(MEM_PAT)) u_chk (
		.clk        (clk),
		.reset      (reset),
		.inst_req_i (inst_req_i),
		.inst_rd_i  (inst_rd_i),
		.inst_rdy_i (inst_rdy_o),
		.inst_ret_i (inst_ret_o),
		.data_req_i (data_req_i),
		.data_rd_i  (data_rd_i),
		.data_rdy_i (data_rdy_o),
		.data_ret_i (data_ret_o),
		.wr_req_i   (wr_req_i),
		.wr_i       (wr_i),
		.wr_rdy_i   (wr_rdy_o),
		.arvalid_i  (arvalid_o),
		.rready_i   (rready_o),
		.aw_i       (aw_o),
		.awvalid_i  (awvalid_o),
		.awready_i  (awready_i),
		.wvalid_i   (wvalid_o),
		.bvalid_i   (bvalid_i),
		.bready_i   (bready_o),
		.end_check_i (end_check),
		.errors_o   (errors)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = word_t'(i * 4) ^ MEM_PAT;
		end
	end

	// read side, stalls of 0 to 3 cycles on arready and each rvalid
	always @(posedge clk) begin
		if (reset) begin
			arready_i <= 1'b0;
			rvalid_i  <= 1'b0;
			rd_busy   <= 1'b0;
			rd_wait   <= 2'($urandom_range(3));
		end else if (!rd_busy) begin
			if (arvalid_o && arready_i) begin
				arready_i <= 1'b0;
				rd_busy   <= 1'b1;
				rd_id     <= ar_o.id;
				rd_addr   <= ar_o.addr;
				rd_left   <= ar_o.len;
				rd_wait   <= 2'($urandom_range(3));
			end else if (arvalid_o && rd_wait == 0) begin
				arready_i <= 1'b1;
			end else if (arvalid_o) begin
				rd_wait <= rd_wait - 1'b1;
			end
		end else if (rvalid_i && rready_o) begin
			rvalid_i <= 1'b0;
			rd_addr  <= rd_addr + 32'd4;
			rd_left  <= rd_left - 1'b1;
			rd_wait  <= 2'($urandom_range(3));
			if (r_i.last) begin
				rd_busy <= 1'b0;
			end
		end else if (!rvalid_i && rd_wait == 0) begin
			rvalid_i <= 1'b1;
			r_i <= '{id: rd_id, data: mem[rd_addr[9:2]], resp: 2'b00, last: rd_left == 8'd0};
		end else if (!rvalid_i) begin
			rd_wait <= rd_wait - 1'b1;
		end
	end

	// write side, phase 0 AW, 1 W beats, 2 B
	always @(posedge clk) begin
		word_t merged;
		if (reset) begin
			awready_i <= 1'b0;
			wready_i  <= 1'b0;
			bvalid_i  <= 1'b0;
			wr_phase  <= 2'd0;
			wr_wait   <= 2'($urandom_range(3));
		end else if (wr_phase == 2'd0) begin
			if (awvalid_o && awready_i) begin
				awready_i <= 1'b0;
				wr_id     <= aw_o.id;
				wr_addr   <= aw_o.addr;
				wr_phase  <= 2'd1;
				wr_wait   <= 2'($urandom_range(3));
			end else if (awvalid_o && wr_wait == 0) begin
				awready_i <= 1'b1;
			end else if (awvalid_o) begin
				wr_wait <= wr_wait - 1'b1;
			end
		end else if (wr_phase == 2'd1) begin
			if (wvalid_o && wready_i) begin
				merged = mem[wr_addr[9:2]];
				for (int b = 0; b < 4; b++) begin
					if (w_o.strb[b]) begin
						merged[b*8 +: 8] = w_o.data[b*8 +: 8];
					end
				end
				mem[wr_addr[9:2]] <= merged;
				wready_i <= 1'b0;
				wr_addr  <= wr_addr + 32'd4;
				wr_wait  <= 2'($urandom_range(3));
				if (w_o.last) begin
					wr_phase <= 2'd2;
				end
			end else if (wvalid_o && wr_wait == 0) begin
				wready_i <= 1'b1;
			end else if (wvalid_o) begin
				wr_wait <= wr_wait - 1'b1;
			end
		end else if (bvalid_i && bready_o) begin
			bvalid_i <= 1'b0;
			wr_phase <= 2'd0;
			wr_wait  <= 2'($urandom_range(3));
		end else if (!bvalid_i && wr_wait == 0) begin
			bvalid_i <= 1'b1;
			b_i      <= '{id: wr_id, resp: 2'b00};
		end else if (!bvalid_i) begin
			wr_wait <= wr_wait - 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// one row, held until every request in it is taken
	task automatic apply_row(input stim_t s);
		logic i_pend;
		logic d_pend;
		logic w_pend;
		@(posedge clk);
		i_pend = (s.client == CL_INST) || (s.client == CL_BOTH);
		d_pend = (s.client == CL_DATA) || (s.client == CL_BOTH);
		w_pend = (s.client == CL_WR);
		inst_req_i <= i_pend;
		data_req_i <= d_pend;
		wr_req_i   <= w_pend;
		// inst side of a paired row reads another line
		inst_rd_i <= '{addr: (s.client == CL_BOTH) ? s.addr ^ 32'h200 : s.addr, kind: s.kind};
		data_rd_i <= '{addr: s.addr, kind: s.kind};
		wr_i      <= '{addr: s.addr, kind: s.kind, strb: s.strb, line: s.line};
		while (i_pend || d_pend || w_pend) begin
			@(posedge clk);
			if (i_pend && inst_rdy_o) begin
				i_pend = 1'b0;
				inst_req_i <= 1'b0;
			end
			if (d_pend && data_rdy_o) begin
				d_pend = 1'b0;
				data_req_i <= 1'b0;
			end
			if (w_pend && wr_rdy_o) begin
				w_pend = 1'b0;
				wr_req_i <= 1'b0;
			end
		end
	endtask

	initial begin
		void'($urandom(85183));
		reset      = 1'b1;
		inst_req_i = 1'b0;
		data_req_i = 1'b0;
		wr_req_i   = 1'b0;
		inst_rd_i  = '0;
		data_rd_i  = '0;
		wr_i       = '0;
		rows[0]  = '{CL_INST, XFER_LINE, 32'h040, 4'h0, '0};
		rows[1]  = '{CL_DATA, XFER_WORD, 32'h084, 4'h0, '0};
		rows[2]  = '{CL_BOTH, XFER_LINE, 32'h100, 4'h0, '0};
		rows[3]  = '{CL_WR, XFER_LINE, 32'h180, 4'hf, 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0};
		rows[4]  = '{CL_DATA, XFER_LINE, 32'h180, 4'h0, '0};
		rows[5]  = '{CL_INST, XFER_WORD, 32'h18c, 4'h0, '0};
		rows[6]  = '{CL_WR, XFER_WORD, 32'h208, 4'b0101, 128'h11223344};
		rows[7]  = '{CL_DATA, XFER_WORD, 32'h208, 4'h0, '0};
		rows[8]  = '{CL_BOTH, XFER_WORD, 32'h044, 4'h0, '0};
		rows[9]  = '{CL_WR, XFER_LINE, 32'h3f0, 4'hf, 128'h13579bdf_2468ace0_fdb97531_0eca8642};
		rows[10] = '{CL_INST, XFER_LINE, 32'h3f0, 4'h0, '0};
		rows[11] = '{CL_WR, XFER_WORD, 32'h00c, 4'b1000, 128'ha1b2c3d4};
		rows[12] = '{CL_DATA, XFER_WORD, 32'h00c, 4'h0, '0};
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		// idle stretch after reset
		repeat (4) @(posedge clk);
		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_row(rows[i]);
		end
		@(posedge clk);
		while (!(inst_rdy_o && data_rdy_o && wr_rdy_o)) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		// every expected beat and write response must have arrived
		end_check <= 1'b1;
		@(posedge clk);
		end_check <= 1'b0;
		@(posedge clk);
		$display("run finished after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
